// ==== logic/light_config.svh ====
`ifndef LIGHT_CONFIG_SVH
`define LIGHT_CONFIG_SVH

// width of one light pattern or one button wiring mask.
`define MAX_WIRING_WIDTH 16

// button slots held per machine; more than this on a line are dropped.
`define MAX_BUTTONS 10

// width of the running sums.
`define TOTAL_WIDTH 32

`endif

// ==== logic/light_pkg.sv ====
`include "light_config.svh"

package light_pkg;

    // byte codes the line decoder reacts to, in ASCII.
    typedef enum logic [7:0] {
        NUL_CHAR       = 8'h00,
        LF_CHAR        = 8'h0A,
        SPACE_CHAR     = 8'h20,
        HASH_CHAR      = 8'h23, // light on.
        L_PAREN_CHAR   = 8'h28,
        R_PAREN_CHAR   = 8'h29, // closes a button group.
        COMMA_CHAR     = 8'h2C,
        DOT_CHAR       = 8'h2E, // light off.
        ZERO_CHAR      = 8'h30,
        NINE_CHAR      = 8'h39,
        R_BRACKET_CHAR = 8'h5D, // closes the light group.
        L_BRACE_CHAR   = 8'h7B
    } char_t;

    typedef logic [`MAX_WIRING_WIDTH-1:0] wiring_t; // bit 0 is the first light.

    typedef logic [3:0] button_count_t; // 0 to 10 buttons.

    typedef logic [3:0] press_count_t;

    typedef logic [`TOTAL_WIDTH-1:0] total_t;

endpackage

// ==== logic/line_decoder.sv ====
`timescale 1ns/1ns
`include "light_config.svh"

module line_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               inbound_valid,
    input  light_pkg::char_t   inbound_byte,
    output logic               wiring_valid,
    output logic               wiring_is_light,
    output light_pkg::wiring_t wiring_data,
    output logic               end_of_line,
    output logic               end_of_file
);
    import light_pkg::*;

    wiring_t                              light_mask;
    wiring_t                              button_mask;
    logic [$clog2(`MAX_WIRING_WIDTH)-1:0] light_index;
    logic                                 is_digit;
    logic [3:0]                           digit_index;

    assign is_digit = (inbound_byte >= ZERO_CHAR) && (inbound_byte <= NINE_CHAR);
    assign digit_index = 4'(inbound_byte - ZERO_CHAR);

    // light pattern, first light lands in bit 0.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            light_mask <= '0;
            light_index <= '0;
        end else if (inbound_valid) begin
            case (inbound_byte)
                DOT_CHAR, HASH_CHAR: begin
                    if (inbound_byte == HASH_CHAR) begin
                        light_mask[light_index] <= 1'b1;
                    end
                    light_index <= light_index + 1'b1;
                end
                LF_CHAR: begin
                    light_mask <= '0;
                    light_index <= '0;
                end
                default: begin
                end
            endcase
        end
    end

    // brace digits land here too but are never committed.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            button_mask <= '0;
        end else if (inbound_valid) begin
            if (inbound_byte == SPACE_CHAR) begin
                button_mask <= '0;
            end else if (is_digit) begin
                button_mask[digit_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wiring_valid <= 1'b0;
            end_of_line <= 1'b0;
            end_of_file <= 1'b0;
        end else begin
            wiring_valid <= 1'b0;
            end_of_line <= 1'b0;
            if (inbound_valid) begin
                case (inbound_byte)
                    R_BRACKET_CHAR, R_PAREN_CHAR: begin
                        wiring_valid <= 1'b1;
                    end
                    LF_CHAR: begin
                        end_of_line <= 1'b1;
                    end
                    NUL_CHAR: begin
                        end_of_file <= 1'b1; // held until reset.
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inbound_valid && (inbound_byte == R_BRACKET_CHAR)) begin
            wiring_data <= light_mask;
            wiring_is_light <= 1'b1;
        end else if (inbound_valid && (inbound_byte == R_PAREN_CHAR)) begin
            wiring_data <= button_mask;
            wiring_is_light <= 1'b0;
        end
    end

endmodule

// ==== logic/button_collector.sv ====
`timescale 1ns/1ns
`include "light_config.svh"

module button_collector (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    wiring_valid,
    input  logic                    wiring_is_light,
    input  light_pkg::wiring_t      wiring_data,
    input  logic                    end_of_line,
    input  logic                    solver_busy,
    output logic                    machine_valid,
    output light_pkg::wiring_t      target,
    output light_pkg::wiring_t      button_masks [`MAX_BUTTONS],
    output light_pkg::button_count_t button_count,
    output logic                    busy
);
    import light_pkg::*;

    wiring_t       line_target;
    wiring_t       line_masks [`MAX_BUTTONS];
    button_count_t line_count;
    logic          has_light;
    logic          line_done;
    logic          line_filled;
    logic          room_left;
    logic          transfer;
    logic          line_clear;

    assign line_filled = has_light || (line_count != '0);
    assign room_left = line_count < button_count_t'(`MAX_BUTTONS);

    // a finished line goes out in the same cycle when the solver is free.
    assign transfer = !solver_busy && (line_done || (end_of_line && line_filled));
    assign line_clear = transfer || (end_of_line && !line_filled); // empty lines vanish.

    assign busy = line_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_target <= '0;
            line_count <= '0;
            has_light <= 1'b0;
            line_done <= 1'b0;
            machine_valid <= 1'b0;
        end else begin
            machine_valid <= transfer;
            if (line_clear) begin
                line_target <= '0;
                line_count <= '0;
                has_light <= 1'b0;
            end else if (wiring_valid) begin
                if (wiring_is_light) begin
                    line_target <= wiring_data;
                    has_light <= 1'b1;
                end else if (room_left) begin
                    line_count <= line_count + 1'b1;
                end
            end
            if (transfer) begin
                line_done <= 1'b0;
            end else if (end_of_line && line_filled) begin
                line_done <= 1'b1; // waits here while the solver works.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!line_clear && wiring_valid && !wiring_is_light && room_left) begin
            line_masks[line_count] <= wiring_data;
        end
    end

    // slots past button_count hold stale masks, the solver never selects them.
    always_ff @(posedge clk) begin
        if (transfer) begin
            target <= line_target;
            button_masks <= line_masks;
            button_count <= line_count;
        end
    end

endmodule

// ==== logic/press_solver.sv ====
`timescale 1ns/1ns
`include "light_config.svh"

module press_solver (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     machine_valid,
    input  light_pkg::wiring_t       target,
    input  light_pkg::wiring_t       button_masks [`MAX_BUTTONS],
    input  light_pkg::button_count_t button_count,
    output logic                     solver_busy,
    output logic                     result_valid,
    output light_pkg::press_count_t  min_presses,
    output logic                     unsolvable
);
    import light_pkg::*;

    wiring_t                   target_q;
    wiring_t                   masks_q [`MAX_BUTTONS];
    button_count_t             count_q;
    logic [`MAX_BUTTONS-1:0]   subset;
    logic [`MAX_BUTTONS:0]     subset_end;
    logic                      last_subset;
    wiring_t                   pattern;
    press_count_t              presses;
    logic                      hit;
    logic                      found;
    logic                      found_next;
    press_count_t              best;
    press_count_t              best_next;

    // one past the last subset, 2 to the power of the button count.
    assign subset_end = {{`MAX_BUTTONS{1'b0}}, 1'b1} << count_q;
    assign last_subset = (({1'b0, subset} + 1'b1) == subset_end);

    // lights reached by pressing each selected button once.
    always_comb begin
        pattern = '0;
        presses = '0;
        for (int i = 0; i < `MAX_BUTTONS; i++) begin
            if (subset[i]) begin
                pattern = pattern ^ masks_q[i];
                presses = presses + press_count_t'(1);
            end
        end
    end

    assign hit = (pattern == target_q);

    always_comb begin
        found_next = found || hit;
        best_next = best;
        if (hit && (!found || (presses < best))) begin
            best_next = presses;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            solver_busy <= 1'b0;
            result_valid <= 1'b0;
            subset <= '0;
            found <= 1'b0;
            best <= '0;
        end else begin
            result_valid <= 1'b0;
            if (machine_valid) begin
                solver_busy <= 1'b1;
                subset <= '0;
                found <= 1'b0;
                best <= '0;
            end else if (solver_busy) begin
                subset <= subset + 1'b1;
                found <= found_next;
                best <= best_next;
                if (last_subset) begin
                    solver_busy <= 1'b0;
                    result_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (machine_valid) begin
            target_q <= target;
            masks_q <= button_masks;
            count_q <= button_count;
        end
    end

    // the last subset's match is folded in through best_next.
    always_ff @(posedge clk) begin
        if (solver_busy && last_subset) begin
            min_presses <= found_next ? best_next : '0;
            unsolvable <= !found_next;
        end
    end

endmodule

// ==== logic/press_totalizer.sv ====
`timescale 1ns/1ns

module press_totalizer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    result_valid,
    input  light_pkg::press_count_t min_presses,
    input  logic                    unsolvable,
    input  logic                    end_of_file,
    input  logic                    busy,
    input  logic                    solver_busy,
    output light_pkg::total_t       total_presses,
    output light_pkg::total_t       machine_count,
    output light_pkg::total_t       unsolved_count,
    output logic                    done
);
    import light_pkg::*;

    logic quiet;
    logic quiet_q;

    assign quiet = end_of_file && !busy && !solver_busy && !result_valid;

    // A machine handed over by the collector shows on solver_busy one cycle late,
    // so the stream must look quiet for two cycles in a row.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            total_presses <= '0;
            machine_count <= '0;
            unsolved_count <= '0;
            quiet_q <= 1'b0;
            done <= 1'b0;
        end else begin
            quiet_q <= quiet;
            if (quiet && quiet_q) begin
                done <= 1'b1;
            end
            if (result_valid) begin
                machine_count <= machine_count + total_t'(1);
                if (unsolvable) begin
                    unsolved_count <= unsolved_count + total_t'(1);
                end else begin
                    total_presses <= total_presses + total_t'(min_presses);
                end
            end
        end
    end

endmodule

// ==== logic/factory_top.sv ====
`timescale 1ns/1ns
`include "light_config.svh"

module factory_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    inbound_valid,
    input  light_pkg::char_t        inbound_byte,
    output logic                    busy,
    output logic                    result_valid,
    output light_pkg::press_count_t min_presses,
    output logic                    unsolvable,
    output light_pkg::total_t       total_presses,
    output light_pkg::total_t       machine_count,
    output light_pkg::total_t       unsolved_count,
    output logic                    done
);
    import light_pkg::*;

    logic          wiring_valid;
    logic          wiring_is_light;
    wiring_t       wiring_data;
    logic          end_of_line;
    logic          end_of_file;
    logic          machine_valid;
    wiring_t       target;
    wiring_t       button_masks [`MAX_BUTTONS];
    button_count_t button_count;
    logic          solver_busy;

    line_decoder u_line_decoder (
        .clk             (clk),
        .arst_n          (arst_n),
        .inbound_valid   (inbound_valid),
        .inbound_byte    (inbound_byte),
        .wiring_valid    (wiring_valid),
        .wiring_is_light (wiring_is_light),
        .wiring_data     (wiring_data),
        .end_of_line     (end_of_line),
        .end_of_file     (end_of_file)
    );

    button_collector u_button_collector (
        .clk             (clk),
        .arst_n          (arst_n),
        .wiring_valid    (wiring_valid),
        .wiring_is_light (wiring_is_light),
        .wiring_data     (wiring_data),
        .end_of_line     (end_of_line),
        .solver_busy     (solver_busy),
        .machine_valid   (machine_valid),
        .target          (target),
        .button_masks    (button_masks),
        .button_count    (button_count),
        .busy            (busy)
    );

    press_solver u_press_solver (
        .clk           (clk),
        .arst_n        (arst_n),
        .machine_valid (machine_valid),
        .target        (target),
        .button_masks  (button_masks),
        .button_count  (button_count),
        .solver_busy   (solver_busy),
        .result_valid  (result_valid),
        .min_presses   (min_presses),
        .unsolvable    (unsolvable)
    );

    press_totalizer u_press_totalizer (
        .clk            (clk),
        .arst_n         (arst_n),
        .result_valid   (result_valid),
        .min_presses    (min_presses),
        .unsolvable     (unsolvable),
        .end_of_file    (end_of_file),
        .busy           (busy),
        .solver_busy    (solver_busy),
        .total_presses  (total_presses),
        .machine_count  (machine_count),
        .unsolved_count (unsolved_count),
        .done           (done)
    );

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #10 arst_n = 1'b1; // released off the edge, like the stimulus.
    end

endmodule

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ns

module tb_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    busy,
    input  logic                    result_valid,
    input  light_pkg::press_count_t min_presses,
    input  logic                    unsolvable,
    input  light_pkg::total_t       total_presses,
    input  light_pkg::total_t       machine_count,
    input  light_pkg::total_t       unsolved_count,
    input  logic                    done,
    output int                      error_count,
    output logic                    finished
);
    import light_pkg::*;

    press_count_t expected_presses [$];
    logic         expected_unsolvable [$];
    total_t       sum_presses = '0;
    total_t       sum_machines = '0;
    total_t       sum_unsolved = '0;
    int           value_errors = 0;
    int           other_errors = 0;
    int           result_count = 0;
    logic         arst_q = 1'b0;

    assign error_count = value_errors + other_errors;

    initial finished = 1'b0;

    function automatic void push_expected(input press_count_t presses, input logic no_solution);
        expected_presses.push_back(presses);
        expected_unsolvable.push_back(no_solution);
        sum_machines = sum_machines + total_t'(1);
        if (no_solution) begin
            sum_unsolved = sum_unsolved + total_t'(1);
        end else begin
            sum_presses = sum_presses + total_t'(presses);
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] want, input logic [31:0] got);
        if (got !== want) begin
            $display("FAIL %s expected %h actual %h", name, want, got);
            value_errors++;
        end
    endtask

    // outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!arst_n || !arst_q) begin
            check_value("result_valid", 32'h0, 32'(result_valid));
            check_value("busy", 32'h0, 32'(busy));
            check_value("done", 32'h0, 32'(done));
            check_value("total_presses", 32'h0, 32'(total_presses));
            check_value("machine_count", 32'h0, 32'(machine_count));
            check_value("unsolved_count", 32'h0, 32'(unsolved_count));
        end else if (!finished) begin
            if (result_valid && expected_presses.size() == 0) begin
                $display("a result arrived although no machine was waiting for one");
                other_errors++;
            end else if (result_valid) begin
                check_value("min_presses", 32'(expected_presses.pop_front()), 32'(min_presses));
                check_value("unsolvable", 32'(expected_unsolvable.pop_front()), 32'(unsolvable));
                result_count++;
            end
            if (done) begin
                if (expected_presses.size() != 0) begin
                    $display("done rose with %0d results never delivered", expected_presses.size());
                    other_errors++;
                end
                check_value("total_presses", 32'(sum_presses), 32'(total_presses));
                check_value("machine_count", 32'(sum_machines), 32'(machine_count));
                check_value("unsolved_count", 32'(sum_unsolved), 32'(unsolved_count));
                $display("checker: %0d results, %0d value errors, %0d other errors",
                         result_count, value_errors, other_errors);
                finished = 1'b1;
            end
        end
        arst_q = arst_n;
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;
    import light_pkg::*;

    localparam int LINE_COUNT = 40;
    localparam int WATCHDOG_NS = LINE_COUNT * (60 + 1025) * 2 * 100;

    logic         clk;
    logic         arst_n;
    logic         inbound_valid;
    char_t        inbound_byte;
    logic         busy;
    logic         result_valid;
    press_count_t min_presses;
    logic         unsolvable;
    total_t       total_presses;
    total_t       machine_count;
    total_t       unsolved_count;
    logic         done;
    int           error_count;
    logic         finished;

    tb_clock u_clock (.clk(clk), .arst_n(arst_n));

    factory_top DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .inbound_valid  (inbound_valid),
        .inbound_byte   (inbound_byte),
        .busy           (busy),
        .result_valid   (result_valid),
        .min_presses    (min_presses),
        .unsolvable     (unsolvable),
        .total_presses  (total_presses),
        .machine_count  (machine_count),
        .unsolved_count (unsolved_count),
        .done           (done)
    );

    tb_checker u_checker (
        .clk            (clk),
        .arst_n         (arst_n),
        .busy           (busy),
        .result_valid   (result_valid),
        .min_presses    (min_presses),
        .unsolvable     (unsolvable),
        .total_presses  (total_presses),
        .machine_count  (machine_count),
        .unsolved_count (unsolved_count),
        .done           (done),
        .error_count    (error_count),
        .finished       (finished)
    );

    function automatic string build_line();
        string       text;
        int          lights;
        int          reserved;
        int          reach;
        int          buttons;
        int          picks;
        int          idx;
        logic [15:0] used;
        text = "[";
        lights = $urandom_range(1, 10);
        reserved = ($urandom_range(0, 3) == 0) ? 1 : 0; // last light on, and no button reaches it.
        reach = lights - reserved;
        for (int i = 0; i < lights; i++) begin
            if ((reserved == 1 && i == lights - 1) || $urandom_range(0, 1) == 1) begin
                text = {text, "#"};
            end else begin
                text = {text, "."};
            end
        end
        text = {text, "]"};
        buttons = (reach == 0) ? 0 : $urandom_range(0, 10);
        for (int b = 0; b < buttons; b++) begin
            picks = $urandom_range(1, (reach < 4) ? reach : 4);
            used = '0;
            text = {text, " ("};
            for (int p = 0; p < picks; p++) begin
                do begin
                    idx = $urandom_range(0, reach - 1);
                end while (((used >> idx) & 16'h1) != 16'h0);
                used = used | (16'h1 << idx);
                if (p > 0) begin
                    text = {text, ","};
                end
                text = {text, $sformatf("%0d", idx)};
            end
            text = {text, ")"};
        end
        text = {text, " {", $sformatf("%0d", $urandom_range(0, 300))};
        for (int k = $urandom_range(0, 3); k > 0; k--) begin
            text = {text, ",", $sformatf("%0d", $urandom_range(0, 300))};
        end
        return {text, "}"};
    endfunction

    // parses one line of text and tries every button subset.
    function automatic void solve_line(input string text);
        logic [15:0] target;
        logic [15:0] mask;
        logic [15:0] pattern;
        logic [15:0] masks [$];
        int          light;
        int          ones;
        int          best;
        logic        in_brace;
        byte         c;
        target = '0;
        mask = '0;
        light = 0;
        best = -1;
        in_brace = 1'b0;
        for (int i = 0; i < text.len(); i++) begin
            c = text[i];
            if (c == "{" || c == "}") begin
                in_brace = (c == "{");
            end else if (!in_brace) begin
                if (c == "#") begin
                    target = target | (16'h1 << light);
                end
                if (c == "#" || c == ".") begin
                    light++;
                end else if (c == "(") begin
                    mask = '0;
                end else if (c == ")") begin
                    masks.push_back(mask);
                end else if (c >= "0" && c <= "9") begin
                    mask = mask | (16'h1 << (c - "0"));
                end
            end
        end
        for (int s = 0; s < (1 << masks.size()); s++) begin
            pattern = '0;
            ones = 0;
            for (int j = 0; j < masks.size(); j++) begin
                if (((s >> j) & 1) == 1) begin
                    pattern = pattern ^ masks[j];
                    ones++;
                end
            end
            if (pattern == target && (best < 0 || ones < best)) begin
                best = ones;
            end
        end
        u_checker.push_expected((best < 0) ? '0 : press_count_t'(best), best < 0);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic send_byte(input logic [7:0] value);
        if ($urandom_range(0, 3) == 0) begin
            repeat ($urandom_range(1, 3)) next_cycle();
        end
        while (busy) begin
            next_cycle();
        end
        inbound_valid = 1'b1;
        inbound_byte = char_t'(value);
        next_cycle();
        inbound_valid = 1'b0;
    endtask

    task automatic end_line();
        send_byte(LF_CHAR);
        repeat (2) next_cycle(); // busy shows two cycles after the LF byte.
    endtask

    initial begin
        int    seed_value;
        string text;
        inbound_valid = 1'b0;
        inbound_byte = NUL_CHAR;
        seed_value = $urandom(92100);
        wait (arst_n === 1'b1);
        next_cycle();
        for (int n = 0; n < LINE_COUNT; n++) begin
            text = build_line();
            solve_line(text);
            for (int i = 0; i < text.len(); i++) begin
                send_byte(text[i]);
            end
            end_line();
        end
        end_line(); // an empty line gives no machine.
        send_byte(NUL_CHAR);
        wait (finished === 1'b1);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the DUT raised done");
        $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/light_pkg.sv
logic/line_decoder.sv
logic/button_collector.sv
logic/press_solver.sv
logic/press_totalizer.sv
logic/factory_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message in log.txt.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir log.txt
if ! verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module tb_top -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi
if ! ./obj_dir/Vtb_top > log.txt 2>&1; then
    cat log.txt
    echo "simulation exited with an error"
    exit 1
fi
cat log.txt
if grep -qx "test passed" log.txt; then
    exit 0
fi
exit 1
